/* verilog/mpm_macros.svh */
// MPM constants for limb sizes, operand widths and the AXI4-Lite port
`ifndef MPM_MACROS_SVH
`define MPM_MACROS_SVH

// Operands are split into 16-bit limbs
`define MPM_NUM_LIMBS 4
`define MPM_WORD_LEN 16
`define MPM_DSP_BIT_LEN 17 // Limb value plus one carry bit

// Operand and full product widths
`define MPM_OPER_W 64
`define MPM_PROD_W 128

// Register port
`define MPM_AXI_ADDR_W 8
`define MPM_AXI_DATA_W 32

`endif

/* verilog/mpm_arith_pkg.sv */
// MPM arithmetic types for plain limbs and redundant limb words
`include "mpm_macros.svh"

package mpm_arith_pkg;

  typedef logic [`MPM_WORD_LEN-1:0] word_t; // One limb value

  // Redundant limb
  // Column sums work on the raw word, the accumulator splits it
  typedef union packed {
    logic [`MPM_DSP_BIT_LEN-1:0] raw;
    struct packed {
      logic                     carry; // Weight of the next limb up
      logic [`MPM_WORD_LEN-1:0] value;
    } part;
  } limb_t;

endpackage

/* verilog/mpm_regs_pkg.sv */
// MPM register map offsets, control fields and sequencer states
`include "mpm_macros.svh"

package mpm_regs_pkg;

  localparam logic [`MPM_AXI_ADDR_W-1:0] REG_CTRL   = 8'h00;
  localparam logic [`MPM_AXI_ADDR_W-1:0] REG_STATUS = 8'h04; // Read only
  localparam logic [`MPM_AXI_ADDR_W-1:0] REG_A_LO   = 8'h08;
  localparam logic [`MPM_AXI_ADDR_W-1:0] REG_A_HI   = 8'h0C;
  localparam logic [`MPM_AXI_ADDR_W-1:0] REG_B_LO   = 8'h10;
  localparam logic [`MPM_AXI_ADDR_W-1:0] REG_B_HI   = 8'h14;
  localparam logic [`MPM_AXI_ADDR_W-1:0] REG_C_LO   = 8'h18;
  localparam logic [`MPM_AXI_ADDR_W-1:0] REG_C_HI   = 8'h1C;
  localparam logic [`MPM_AXI_ADDR_W-1:0] REG_P0     = 8'h20; // Least significant word
  localparam logic [`MPM_AXI_ADDR_W-1:0] REG_P1     = 8'h24;
  localparam logic [`MPM_AXI_ADDR_W-1:0] REG_P2     = 8'h28;
  localparam logic [`MPM_AXI_ADDR_W-1:0] REG_P3     = 8'h2C;

  // Bit positions in CTRL and STATUS
  localparam int CTRL_START_BIT  = 0;
  localparam int CTRL_ITER_LSB   = 8; // Count in bits 15:8
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_LAUNCH,  // Check steps left, issue operands
    SEQ_WAIT,    // Pipeline in flight
    SEQ_CAPTURE, // Store P and new X
    SEQ_DONE
  } seq_state_t;

endpackage

/* verilog/limb_multiply_accumulate.sv */
// Limb multiply-accumulate, product grid plus addend summed by column into redundant limbs
`timescale 1ns/1ps
`include "mpm_macros.svh"

module limb_multiply_accumulate #(
  parameter int NUM_LIMBS = `MPM_NUM_LIMBS
) (
  input  logic                 clk,
  input  mpm_arith_pkg::word_t x_limbs [NUM_LIMBS],
  input  mpm_arith_pkg::word_t b_limbs [NUM_LIMBS],
  input  mpm_arith_pkg::word_t c_limbs [NUM_LIMBS],
  output mpm_arith_pkg::limb_t limb_sum [2*NUM_LIMBS]
);
  import mpm_arith_pkg::*;

  localparam int WL       = `MPM_WORD_LEN;
  localparam int DSP_W    = `MPM_DSP_BIT_LEN;
  localparam int NUM_COLS = 2*NUM_LIMBS;
  localparam int PROD_W   = 2*WL;
  localparam int COL_W    = WL + $clog2(NUM_COLS + 1); // Every grid row plus the addend

  logic [PROD_W-1:0] mul_r [NUM_LIMBS][NUM_LIMBS]; // Stage 1 limb products
  word_t             add_r [NUM_LIMBS];            // Addend, aligned with the products
  logic [COL_W-1:0]  grid [NUM_COLS][NUM_COLS];    // Indexed [column][row]
  logic [COL_W-1:0]  col_sum [NUM_COLS];
  limb_t             res [NUM_COLS];

  // Stage 1, one DSP multiplier per limb pair
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_LIMBS; i++) begin
      add_r[i] <= c_limbs[i];
      for (int j = 0; j < NUM_LIMBS; j++) begin
        mul_r[i][j] <= PROD_W'(x_limbs[i]) * PROD_W'(b_limbs[j]);
      end
    end
  end

  // Row 2i gets the low halves of x limb i, row 2i+1 the high halves one column up
  always_comb begin
    for (int c = 0; c < NUM_COLS; c++) begin
      for (int r = 0; r < NUM_COLS; r++) begin
        grid[c][r] = '0;
      end
    end
    for (int i = 0; i < NUM_LIMBS; i++) begin
      for (int j = 0; j < NUM_LIMBS; j++) begin
        grid[i+j][2*i]     = COL_W'(mul_r[i][j][WL-1:0]);
        grid[i+j+1][2*i+1] = COL_W'(mul_r[i][j][PROD_W-1:WL]);
      end
    end
  end

  // Column sums with addend in the low columns
  always_comb begin
    for (int c = 0; c < NUM_COLS; c++) begin
      col_sum[c] = '0;
      for (int r = 0; r < NUM_COLS; r++) begin
        col_sum[c] = col_sum[c] + grid[c][r];
      end
    end
    for (int i = 0; i < NUM_LIMBS; i++) begin
      col_sum[i] = col_sum[i] + COL_W'(add_r[i]);
    end

    // Bits above 16 of each column move up one column
    // Sum stays below 2^16 + 2^4, so a single carry bit is enough
    res[0].raw = DSP_W'(col_sum[0][WL-1:0]);
    for (int c = 1; c < NUM_COLS; c++) begin
      res[c].raw = DSP_W'(col_sum[c][WL-1:0]) + DSP_W'(col_sum[c-1][COL_W-1:WL]);
    end
  end

  // Stage 2, redundant limbs out
  always_ff @(posedge clk) begin
    for (int c = 0; c < NUM_COLS; c++) begin
      limb_sum[c] <= res[c];
    end
  end

endmodule

/* verilog/mpm_accumulator.sv */
// MPM accumulator, resolves redundant limbs to the exact product and holds state X
`timescale 1ns/1ps
`include "mpm_macros.svh"

module mpm_accumulator (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   load_state, // Run start, X gets A
  input  logic                   capture,    // End of step, X gets low half of P
  input  logic [`MPM_OPER_W-1:0] a_value,
  input  mpm_arith_pkg::limb_t   limb_sum [2*`MPM_NUM_LIMBS],
  output mpm_arith_pkg::word_t   x_limbs [`MPM_NUM_LIMBS],
  output logic [`MPM_PROD_W-1:0] product
);

  localparam int WL       = `MPM_WORD_LEN;
  localparam int NUM_COLS = 2*`MPM_NUM_LIMBS;

  logic [NUM_COLS-1:0]    carry_below; // Carry bit of the limb underneath
  logic [WL:0]            digit;
  logic                   chain;
  logic [`MPM_PROD_W-1:0] exact;
  logic [`MPM_OPER_W-1:0] x_r;

  always_comb begin
    carry_below[0] = 1'b0;
    for (int i = 1; i < NUM_COLS; i++) begin
      carry_below[i] = limb_sum[i-1].part.carry;
    end
    chain = 1'b0;
    for (int i = 0; i < NUM_COLS; i++) begin
      digit = (WL+1)'(limb_sum[i].part.value) + (WL+1)'(carry_below[i]) + (WL+1)'(chain);
      exact[i*WL +: WL] = digit[WL-1:0];
      chain = digit[WL]; // Ripple into the next digit, top one is always clear
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      x_r     <= '0;
      product <= '0;
    end else if (load_state) begin
      x_r     <= a_value;
      product <= `MPM_PROD_W'(a_value); // Zero-extended, result for N of 0
    end else if (capture) begin
      x_r     <= exact[`MPM_OPER_W-1:0];
      product <= exact;
    end
  end

  always_comb begin
    for (int i = 0; i < `MPM_NUM_LIMBS; i++) begin
      x_limbs[i] = x_r[i*WL +: WL];
    end
  end

endmodule

/* verilog/mpm_step_counter.sv */
// MPM step counter, remaining iterations and the pipeline wait timer
`timescale 1ns/1ps

module mpm_step_counter (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  logic       launch,
  input  logic       capture,
  input  logic [7:0] iter_count,
  output logic       steps_left_zero,
  output logic       wait_done
);

  localparam int WAIT_CYCLES = 2; // Multiplier latency
  localparam int WAIT_W      = $clog2(WAIT_CYCLES + 1);

  logic [7:0]        steps_left;
  logic [WAIT_W-1:0] wait_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      steps_left <= '0;
    end else if (start) begin
      steps_left <= iter_count;
    end else if (capture && !steps_left_zero) begin
      steps_left <= steps_left - 8'd1; // One step finished
    end
  end

  // Loaded one short so wait_done shows in the last wait cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cnt <= '0;
    end else if (launch) begin
      wait_cnt <= WAIT_W'(WAIT_CYCLES - 1);
    end else if (!wait_done) begin
      wait_cnt <= wait_cnt - 1'b1;
    end
  end

  assign steps_left_zero = (steps_left == '0);
  assign wait_done       = (wait_cnt == '0);

endmodule

/* verilog/mpm_sequencer.sv */
// MPM sequencer FSM, loads the state, steps the recurrence and flags completion
`timescale 1ns/1ps

module mpm_sequencer (
  input  logic clk,
  input  logic rst,
  input  logic start,           // One-cycle pulse, only while idle
  input  logic steps_left_zero,
  input  logic wait_done,
  output logic load_state,
  output logic launch,
  output logic capture,
  output logic busy,
  output logic done             // Sticky until the next start
);
  import mpm_regs_pkg::*;

  seq_state_t state;
  seq_state_t state_next;

  always_comb begin
    state_next = state;
    case (state)
      SEQ_IDLE: begin
        if (start) state_next = SEQ_LAUNCH; // X loaded on the same edge
      end
      SEQ_LAUNCH: begin
        state_next = steps_left_zero ? SEQ_DONE : SEQ_WAIT;
      end
      SEQ_WAIT: begin
        if (wait_done) state_next = SEQ_CAPTURE;
      end
      SEQ_CAPTURE: state_next = SEQ_LAUNCH; // Back to check the count
      SEQ_DONE:    state_next = SEQ_IDLE;
      default:     state_next = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= SEQ_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Done rises as the FSM returns to idle, so never together with busy
  always_ff @(posedge clk) begin
    if (rst || start) begin
      done <= 1'b0;
    end else if (state == SEQ_DONE) begin
      done <= 1'b1;
    end
  end

  assign load_state = (state == SEQ_IDLE) && start;
  assign launch     = (state == SEQ_LAUNCH) && !steps_left_zero;
  assign capture    = (state == SEQ_CAPTURE);
  assign busy       = (state != SEQ_IDLE);

endmodule

/* verilog/mpm_axil_regs.sv */
// MPM AXI4-Lite register block with operand, control, status and result registers
`timescale 1ns/1ps
`include "mpm_macros.svh"

module mpm_axil_regs (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [`MPM_AXI_ADDR_W-1:0]   awaddr,
  input  logic                         awvalid,
  output logic                         awready,
  input  logic [`MPM_AXI_DATA_W-1:0]   wdata,
  input  logic [`MPM_AXI_DATA_W/8-1:0] wstrb,
  input  logic                         wvalid,
  output logic                         wready,
  output logic [1:0]                   bresp,
  output logic                         bvalid,
  input  logic                         bready,
  input  logic [`MPM_AXI_ADDR_W-1:0]   araddr,
  input  logic                         arvalid,
  output logic                         arready,
  output logic [`MPM_AXI_DATA_W-1:0]   rdata,
  output logic [1:0]                   rresp,
  output logic                         rvalid,
  input  logic                         rready,
  input  logic                         busy,
  input  logic                         done,
  input  logic [`MPM_PROD_W-1:0]       product,
  output logic [`MPM_OPER_W-1:0]       a_value,
  output logic [`MPM_OPER_W-1:0]       b_value,
  output logic [`MPM_OPER_W-1:0]       c_value,
  output logic                         start,
  output logic [7:0]                   iter_count
);
  import mpm_regs_pkg::*;

  localparam int DW = `MPM_AXI_DATA_W;

  logic          wr_fire;
  logic          rd_fire;
  logic          wr_accept;
  logic [DW-1:0] rd_word;

  // Byte lane merge under wstrb
  function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0]   old_w,
                                                input logic [DW-1:0]   new_w,
                                                input logic [DW/8-1:0] strb);
    logic [DW-1:0] merged;
    merged = old_w;
    for (int k = 0; k < DW/8; k++) begin
      if (strb[k]) merged[8*k +: 8] = new_w[8*k +: 8];
    end
    return merged;
  endfunction

  assign wr_fire   = awvalid && awready && wvalid && wready;
  assign rd_fire   = arvalid && arready;
  assign wr_accept = awvalid && wvalid && !bvalid && !awready; // Ready for one cycle only
  assign bresp     = 2'b00; // Always OKAY
  assign rresp     = 2'b00;

  always_ff @(posedge clk) begin
    if (rst) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= wr_accept;
      wready  <= wr_accept;
      if (wr_fire) bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
    end
  end

  // Start and count, start dropped while a run is active
  always_ff @(posedge clk) begin
    if (rst) begin
      start      <= 1'b0;
      iter_count <= '0;
    end else begin
      start <= 1'b0;
      if (wr_fire && awaddr == REG_CTRL && !busy) begin
        iter_count <= wdata[CTRL_ITER_LSB +: 8];
        start      <= wdata[CTRL_START_BIT];
      end
    end
  end

  // Operands, frozen during a run
  always_ff @(posedge clk) begin
    if (wr_fire && !busy) begin
      case (awaddr)
        REG_A_LO: a_value[DW-1:0]    <= merge_bytes(a_value[DW-1:0], wdata, wstrb);
        REG_A_HI: a_value[2*DW-1:DW] <= merge_bytes(a_value[2*DW-1:DW], wdata, wstrb);
        REG_B_LO: b_value[DW-1:0]    <= merge_bytes(b_value[DW-1:0], wdata, wstrb);
        REG_B_HI: b_value[2*DW-1:DW] <= merge_bytes(b_value[2*DW-1:DW], wdata, wstrb);
        REG_C_LO: c_value[DW-1:0]    <= merge_bytes(c_value[DW-1:0], wdata, wstrb);
        REG_C_HI: c_value[2*DW-1:DW] <= merge_bytes(c_value[2*DW-1:DW], wdata, wstrb);
        default: ; // Other offsets are read only or unmapped
      endcase
    end
  end

  always_comb begin
    rd_word = '0; // Unmapped reads give zero
    case (araddr)
      REG_CTRL:   rd_word[CTRL_ITER_LSB +: 8] = iter_count;
      REG_STATUS: begin
        rd_word[STATUS_BUSY_BIT] = busy;
        rd_word[STATUS_DONE_BIT] = done;
      end
      REG_A_LO: rd_word = a_value[DW-1:0];
      REG_A_HI: rd_word = a_value[2*DW-1:DW];
      REG_B_LO: rd_word = b_value[DW-1:0];
      REG_B_HI: rd_word = b_value[2*DW-1:DW];
      REG_C_LO: rd_word = c_value[DW-1:0];
      REG_C_HI: rd_word = c_value[2*DW-1:DW];
      REG_P0:   rd_word = product[0*DW +: DW];
      REG_P1:   rd_word = product[1*DW +: DW];
      REG_P2:   rd_word = product[2*DW +: DW];
      REG_P3:   rd_word = product[3*DW +: DW];
      default:  rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rdata   <= '0;
    end else begin
      arready <= arvalid && !rvalid && !arready;
      if (rd_fire) begin
        rvalid <= 1'b1;
        rdata  <= rd_word; // Held until rready
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

endmodule

/* verilog/mpm_top.sv */
// MPM top, multi-precision multiply-accumulate engine behind an AXI4-Lite port
`timescale 1ns/1ps
`include "mpm_macros.svh"

module mpm_top (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [`MPM_AXI_ADDR_W-1:0]   awaddr,
  input  logic                         awvalid,
  output logic                         awready,
  input  logic [`MPM_AXI_DATA_W-1:0]   wdata,
  input  logic [`MPM_AXI_DATA_W/8-1:0] wstrb,
  input  logic                         wvalid,
  output logic                         wready,
  output logic [1:0]                   bresp,
  output logic                         bvalid,
  input  logic                         bready,
  input  logic [`MPM_AXI_ADDR_W-1:0]   araddr,
  input  logic                         arvalid,
  output logic                         arready,
  output logic [`MPM_AXI_DATA_W-1:0]   rdata,
  output logic [1:0]                   rresp,
  output logic                         rvalid,
  input  logic                         rready
);
  import mpm_arith_pkg::*;

  localparam int WL = `MPM_WORD_LEN;

  logic [`MPM_OPER_W-1:0] a_value;
  logic [`MPM_OPER_W-1:0] b_value;
  logic [`MPM_OPER_W-1:0] c_value;
  logic [`MPM_PROD_W-1:0] product;
  logic [7:0]             iter_count;
  logic                   start, load_state, launch, capture;
  logic                   busy, done, steps_left_zero, wait_done;
  word_t                  x_limbs [`MPM_NUM_LIMBS]; // From the accumulator
  word_t                  b_limbs [`MPM_NUM_LIMBS];
  word_t                  c_limbs [`MPM_NUM_LIMBS];
  limb_t                  limb_sum [2*`MPM_NUM_LIMBS];

  // B and C split into limbs
  always_comb begin
    for (int i = 0; i < `MPM_NUM_LIMBS; i++) begin
      b_limbs[i] = b_value[i*WL +: WL];
      c_limbs[i] = c_value[i*WL +: WL];
    end
  end

  // Port names match the nets one to one
  mpm_axil_regs    u_regs (.*);
  mpm_sequencer    u_seq  (.*);
  mpm_step_counter u_cnt  (.*);
  mpm_accumulator  u_acc  (.*);

  limb_multiply_accumulate #(
    .NUM_LIMBS (`MPM_NUM_LIMBS)
  ) u_lmac (.*);

endmodule

/* verif/mpm_properties.sv */
// MPM bound checks on AXI response holding, busy and done exclusivity and reset values
`timescale 1ns/1ps
`include "mpm_macros.svh"

module mpm_properties (
  input logic                       clk,
  input logic                       rst,
  input logic                       bvalid,
  input logic                       bready,
  input logic                       rvalid,
  input logic                       rready,
  input logic [`MPM_AXI_DATA_W-1:0] rdata,
  input logic                       awready,
  input logic                       wready,
  input logic                       arready,
  input logic                       busy,
  input logic                       done,
  input logic                       start,
  input logic                       load_state,
  input logic                       launch,
  input logic                       capture
);

  // Write response stays up until the master takes it
  bvalid_hold: assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  // Read data must not move while waiting for rready
  rvalid_hold: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("rvalid or rdata changed before rready");

  busy_done_excl: assert property (@(posedge clk) disable iff (rst)
    !(busy && done))
    else $error("busy and done high together");

  // Every handshake output, status flag and internal pulse quiet out of reset
  reset_quiet: assert property (@(posedge clk)
    rst |=> !(bvalid || rvalid || awready || wready || arready || busy || done ||
              start || load_state || launch || capture))
    else $error("output or pulse high right after reset");

endmodule

/* verif/mpm_tb.sv */
// MPM testbench running the multiply-accumulate recurrence over AXI4-Lite against a reference model
`timescale 1ns/1ps
`include "mpm_macros.svh"

module mpm_tb;
  import mpm_regs_pkg::*;

  localparam int HS_LIMIT   = 200;  // Cycles per handshake wait
  localparam int POLL_LIMIT = 1000; // Status reads per run

  logic                         clk;
  logic                         rst;
  logic [`MPM_AXI_ADDR_W-1:0]   awaddr;
  logic                         awvalid;
  logic                         awready;
  logic [`MPM_AXI_DATA_W-1:0]   wdata;
  logic [`MPM_AXI_DATA_W/8-1:0] wstrb;
  logic                         wvalid;
  logic                         wready;
  logic [1:0]                   bresp;
  logic                         bvalid;
  logic                         bready;
  logic [`MPM_AXI_ADDR_W-1:0]   araddr;
  logic                         arvalid;
  logic                         arready;
  logic [`MPM_AXI_DATA_W-1:0]   rdata;
  logic [1:0]                   rresp;
  logic                         rvalid;
  logic                         rready;

  int           errors;
  int           checks;
  int           max_stall; // Upper bound of random bready/rready delay
  bit           hung;
  string        name_q[$]; // Pending checks for the compare process
  logic [127:0] exp_q[$];
  logic [127:0] act_q[$];
  string        cmp_name;
  logic [127:0] cmp_exp;
  logic [127:0] cmp_act;

  mpm_top dut0 (.*);

  bind mpm_top mpm_properties u_props (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk; // 100 ns period

  // P from X = A, then N times P = X*B + C and X = low half of P
  function automatic logic [127:0] mpm_ref(input logic [63:0] a, input logic [63:0] b,
                                           input logic [63:0] c, input logic [7:0] n);
    logic [127:0] p;
    logic [63:0]  x;
    x = a;
    p = {64'h0, a};
    for (int i = 0; i < int'(n); i++) begin
      p = {64'h0, x} * {64'h0, b} + {64'h0, c};
      x = p[63:0];
    end
    return p;
  endfunction

  task automatic push_check(input string name, input logic [127:0] exp_v,
                            input logic [127:0] act_v);
    name_q.push_back(name);
    exp_q.push_back(exp_v);
    act_q.push_back(act_v);
  endtask

  task automatic report_hang(input string what);
    $display("Timeout: no %s within the allowed cycles", what);
    hung = 1'b1;
    errors++;
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
    int cnt;
    int stall;
    if (hung) return;
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    cnt     = 0;
    while (!(awready && wready) && !hung) begin // Ready seen here and accepted on the next edge
      @(negedge clk);
      cnt++;
      if (cnt > HS_LIMIT) report_hang("awready and wready");
    end
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    cnt     = 0;
    while (!bvalid && !hung) begin
      @(negedge clk);
      cnt++;
      if (cnt > HS_LIMIT) report_hang("bvalid");
    end
    push_check("write response", 128'(2'b00), 128'(bresp)); // OKAY
    stall = $urandom_range(max_stall, 0);
    repeat (stall) @(negedge clk); // Back-pressure on b
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
    int cnt;
    int stall;
    data = '0;
    if (hung) return;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    cnt     = 0;
    while (!arready && !hung) begin
      @(negedge clk);
      cnt++;
      if (cnt > HS_LIMIT) report_hang("arready");
    end
    @(negedge clk);
    arvalid = 1'b0;
    cnt     = 0;
    while (!rvalid && !hung) begin
      @(negedge clk);
      cnt++;
      if (cnt > HS_LIMIT) report_hang("rvalid");
    end
    stall = $urandom_range(max_stall, 0);
    repeat (stall) @(negedge clk); // Back-pressure on r
    data   = rdata;
    push_check("read response", 128'(2'b00), 128'(rresp)); // OKAY
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic load_operands(input logic [63:0] a, input logic [63:0] b,
                               input logic [63:0] c);
    axi_write(REG_A_LO, a[31:0]);
    axi_write(REG_A_HI, a[63:32]);
    axi_write(REG_B_LO, b[31:0]);
    axi_write(REG_B_HI, b[63:32]);
    axi_write(REG_C_LO, c[31:0]);
    axi_write(REG_C_HI, c[63:32]);
  endtask

  // A, B, C registers sit at consecutive words from REG_A_LO
  task automatic check_operands(input logic [63:0] a, input logic [63:0] b,
                                input logic [63:0] c);
    logic [191:0] ops;
    logic [31:0]  rd;
    ops = {c, b, a};
    for (int k = 0; k < 6; k++) begin
      axi_read(8'(REG_A_LO + 8'(4*k)), rd);
      push_check("operand read back", 128'(ops[32*k +: 32]), 128'(rd));
    end
  endtask

  task automatic wait_run_done();
    logic [31:0] st;
    int          cnt;
    st  = '0;
    cnt = 0;
    while (!st[STATUS_DONE_BIT] && !hung) begin
      axi_read(REG_STATUS, st);
      if (st[STATUS_BUSY_BIT] && st[STATUS_DONE_BIT]) begin
        $display("Status register shows busy and done at the same time");
        errors++;
      end
      cnt++;
      if (cnt > POLL_LIMIT) report_hang("done flag in the status register");
    end
  endtask

  task automatic read_product(output logic [127:0] p);
    logic [31:0] rd;
    p = '0;
    for (int k = 0; k < 4; k++) begin
      axi_read(8'(REG_P0 + 8'(4*k)), rd); // P0 is the least significant word
      p[32*k +: 32] = rd;
    end
  endtask

  task automatic run_and_check(input string name, input logic [63:0] a, input logic [63:0] b,
                               input logic [63:0] c, input logic [7:0] n);
    logic [127:0] p;
    load_operands(a, b, c);
    axi_write(REG_CTRL, {16'h0, n, 7'h0, 1'b1});
    wait_run_done();
    read_product(p);
    push_check(name, mpm_ref(a, b, c, n), p);
  endtask

  // Compare process drains pending checks on every edge
  always @(posedge clk) begin
    while (act_q.size() > 0) begin
      cmp_name = name_q.pop_front();
      cmp_exp  = exp_q.pop_front();
      cmp_act  = act_q.pop_front();
      checks++;
      if (cmp_act !== cmp_exp) begin
        $display("[ERROR] %s expected %h actual %h", cmp_name, cmp_exp, cmp_act);
        errors++;
      end
    end
  end

  initial begin
    logic [63:0]  a;
    logic [63:0]  b;
    logic [63:0]  c;
    logic [31:0]  st;
    logic [127:0] p;
    void'($urandom(32'h7d59));
    errors    = 0;
    checks    = 0;
    hung      = 1'b0;
    max_stall = 0;
    rst       = 1'b1;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = 4'hF; // Full words only
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    run_and_check("all ones one step", '1, '1, '1, 8'd1); // Longest carry chains

    for (int i = 0; i < 6; i++) begin
      run_and_check("random run", {$urandom, $urandom}, {$urandom, $urandom},
                    {$urandom, $urandom}, 8'($urandom_range(20, 1)));
    end

    a = {$urandom, $urandom};
    run_and_check("zero steps", a, {$urandom, $urandom}, {$urandom, $urandom}, 8'd0);
    axi_read(REG_STATUS, st);
    push_check("status after zero steps", 128'(2'b10), 128'(st[1:0]));

    // Writes and a second start while busy must not disturb the run
    a = {$urandom, $urandom};
    b = {$urandom, $urandom};
    c = {$urandom, $urandom};
    load_operands(a, b, c);
    check_operands(a, b, c);
    axi_write(REG_CTRL, {16'h0, 8'd20, 7'h0, 1'b1});
    axi_read(REG_STATUS, st);
    push_check("status during run", 128'(2'b01), 128'(st[1:0]));
    axi_write(REG_A_LO, ~a[31:0]);
    axi_write(REG_B_HI, ~b[63:32]);
    axi_write(REG_C_LO, ~c[31:0]);
    axi_write(REG_CTRL, {16'h0, 8'd3, 7'h0, 1'b1});
    wait_run_done();
    read_product(p);
    push_check("result with writes while busy", mpm_ref(a, b, c, 8'd20), p);
    check_operands(a, b, c);

    max_stall = 4; // Random b and r back-pressure from here on
    for (int i = 0; i < 6; i++) begin
      a = {$urandom, $urandom};
      b = {$urandom, $urandom};
      c = {$urandom, $urandom};
      run_and_check("stalled run", a, b, c, 8'($urandom_range(12, 1)));
      check_operands(a, b, c);
    end

    repeat (4) @(negedge clk); // Let the compare process drain
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+verilog
verilog/mpm_arith_pkg.sv
verilog/mpm_regs_pkg.sv
verilog/limb_multiply_accumulate.sv
verilog/mpm_accumulator.sv
verilog/mpm_step_counter.sv
verilog/mpm_sequencer.sv
verilog/mpm_axil_regs.sv
verilog/mpm_top.sv
verif/mpm_properties.sv
verif/mpm_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the MPM testbench with Verilator, runs it and scans the log for the fail message
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module mpm_tb \
  -f verilog.f -o mpm_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/mpm_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Test failed" "$SIM_LOG"; then
  exit 1
fi
exit 0
